// File: fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// filter geometry
`define FIR_TAPS   16
`define FIR_LANES  4
`define FIR_BLOCKS (`FIR_TAPS / `FIR_LANES)

// datapath widths
`define SAMPLE_W   16
`define COEF_W     16
// 16 full-scale products fit without overflow
`define ACC_W      40

`endif

// File: fir_pkg.sv
`include "fir_settings.svh"

package fir_pkg;

    // input samples and tap weights
    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef logic signed [`COEF_W-1:0]   coef_t;

    // one lane product, full precision
    typedef logic signed [`SAMPLE_W+`COEF_W-1:0] product_t;

    // block sums, running sum and filter output
    typedef logic signed [`ACC_W-1:0] acc_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ISSUE,
        DRAIN,
        DONE
    } fir_state_e;

endpackage

// File: fir_coef_rom.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_coef_rom (
    input  logic [$clog2(`FIR_BLOCKS)-1:0] block_idx_i,
    output fir_pkg::coef_t                 coef_o [`FIR_LANES]
);

    // first half of the symmetric response, h[k] == h[15-k]
    localparam fir_pkg::coef_t HALF [`FIR_TAPS/2] = '{
        16'sd3,
        -16'sd7,
        16'sd12,
        -16'sd20,
        16'sd41,
        -16'sd85,
        16'sd300,
        16'sd1200
    };

    // mirror the upper half back onto the stored taps
    function automatic fir_pkg::coef_t tap_coef(input int k);
        if (k < `FIR_TAPS/2) begin
            return HALF[k];
        end
        return HALF[`FIR_TAPS-1-k];
    endfunction

    // lane j of block b carries h[b*lanes + j]
    always_comb begin
        for (int j = 0; j < `FIR_LANES; j++) begin
            coef_o[j] = tap_coef(int'(block_idx_i) * `FIR_LANES + j);
        end
    end

endmodule

// File: sample_history.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module sample_history (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           shift_i,
    input  fir_pkg::sample_t               sample_i,
    input  logic [$clog2(`FIR_BLOCKS)-1:0] block_idx_i,
    output fir_pkg::sample_t               taps_o [`FIR_LANES]
);

    // tap 0 holds x[n], tap k holds x[n-k]
    fir_pkg::sample_t hist_q [`FIR_TAPS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `FIR_TAPS; k++) begin
                hist_q[k] <= '0;
            end
        end else if (shift_i) begin
            hist_q[0] <= sample_i;
            for (int k = 1; k < `FIR_TAPS; k++) begin
                hist_q[k] <= hist_q[k-1];
            end
        end
    end

    // selected block of taps, unregistered
    always_comb begin
        for (int j = 0; j < `FIR_LANES; j++) begin
            taps_o[j] = hist_q[int'(block_idx_i) * `FIR_LANES + j];
        end
    end

    // one sample per request, the sequencer never shifts twice back to back
    a_single_shift: assert property (
        @(posedge clk) disable iff (rst)
        shift_i |=> !shift_i
    ) else $error("history shifted in two consecutive cycles");

endmodule

// File: block_mac.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module block_mac (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_i,
    input  fir_pkg::sample_t taps_i [`FIR_LANES],
    input  fir_pkg::coef_t   coef_i [`FIR_LANES],
    output logic             sum_valid_o,
    output fir_pkg::acc_t    block_sum_o
);

    // stage 1, lane products
    fir_pkg::product_t prod_q [`FIR_LANES];
    logic              valid1_q;

    // stage 2, reduced block sum
    fir_pkg::acc_t     sum_q;
    logic              valid2_q;

    // adder tree between the stages
    fir_pkg::acc_t     pair_sum [`FIR_LANES/2];
    fir_pkg::acc_t     tree_sum;

    always_ff @(posedge clk) begin
        if (issue_i) begin
            for (int j = 0; j < `FIR_LANES; j++) begin
                prod_q[j] <= fir_pkg::product_t'(taps_i[j]) * fir_pkg::product_t'(coef_i[j]);
            end
        end
    end

    // first level adds neighbouring lanes, second level folds the pairs
    always_comb begin
        tree_sum = '0;
        for (int p = 0; p < `FIR_LANES/2; p++) begin
            pair_sum[p] = fir_pkg::acc_t'(prod_q[2*p]) + fir_pkg::acc_t'(prod_q[2*p+1]);
            tree_sum    = tree_sum + pair_sum[p];
        end
    end

    always_ff @(posedge clk) begin
        if (valid1_q) begin
            sum_q <= tree_sum;
        end
    end

    // valid travels alongside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= issue_i;
            valid2_q <= valid1_q;
        end
    end

    assign sum_valid_o = valid2_q;
    assign block_sum_o = sum_q;

endmodule

// File: fir_control.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_control (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pause_i,
    input  logic                           sum_valid_i,
    input  fir_pkg::acc_t                  block_sum_i,
    output logic                           shift_o,
    output logic [$clog2(`FIR_BLOCKS)-1:0] block_idx_o,
    output logic                           issue_o,
    output logic                           next_o,
    output logic                           ready_o,
    output fir_pkg::acc_t                  out_o
);

    localparam int IDX_W = $clog2(`FIR_BLOCKS);
    localparam int CNT_W = $clog2(`FIR_BLOCKS + 1);

    localparam logic [IDX_W-1:0] LAST_BLK = IDX_W'(`FIR_BLOCKS - 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`FIR_BLOCKS - 1);

    fir_pkg::fir_state_e state_q;
    fir_pkg::fir_state_e state_d;

    logic [IDX_W-1:0]    blk_q;
    logic [CNT_W-1:0]    sum_cnt_q;
    fir_pkg::acc_t       acc_q;
    fir_pkg::acc_t       acc_d;
    fir_pkg::acc_t       out_q;
    logic                last_sum;

    // final block sum of the current output
    assign last_sum = (state_q == fir_pkg::DRAIN) && sum_valid_i && (sum_cnt_q == LAST_CNT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            fir_pkg::IDLE: begin
                if (!pause_i) begin
                    state_d = fir_pkg::LOAD;
                end
            end
            fir_pkg::LOAD: begin
                state_d = fir_pkg::ISSUE;
            end
            fir_pkg::ISSUE: begin
                if (blk_q == LAST_BLK) begin
                    state_d = fir_pkg::DRAIN;
                end
            end
            fir_pkg::DRAIN: begin
                if (last_sum) begin
                    state_d = fir_pkg::DONE;
                end
            end
            fir_pkg::DONE: begin
                state_d = fir_pkg::IDLE;
            end
            default: begin
                state_d = fir_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= fir_pkg::IDLE;
            blk_q     <= '0;
            sum_cnt_q <= '0;
            out_q     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == fir_pkg::LOAD) begin
                blk_q     <= '0;
                sum_cnt_q <= '0;
            end else begin
                if (issue_o) begin
                    blk_q <= blk_q + 1'b1;
                end
                if (sum_valid_i) begin
                    sum_cnt_q <= sum_cnt_q + 1'b1;
                end
            end
            // result is in place for the DONE cycle
            if (last_sum) begin
                out_q <= acc_d;
            end
        end
    end

    // running sum, early block sums land while later blocks still issue
    assign acc_d = acc_q + block_sum_i;

    always_ff @(posedge clk) begin
        if (state_q == fir_pkg::LOAD) begin
            acc_q <= '0;
        end else if (sum_valid_i) begin
            acc_q <= acc_d;
        end
    end

    assign next_o      = (state_q == fir_pkg::IDLE) && !pause_i;
    assign shift_o     = (state_q == fir_pkg::LOAD);
    assign issue_o     = (state_q == fir_pkg::ISSUE);
    assign ready_o     = (state_q == fir_pkg::DONE);
    assign block_idx_o = blk_q;
    assign out_o       = out_q;

    // every output is built from exactly one sum per block
    a_sum_count: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == fir_pkg::DONE) |-> (sum_cnt_q == CNT_W'(`FIR_BLOCKS))
    ) else $error("wrong number of block sums for this output");

    a_sum_window: assert property (
        @(posedge clk) disable iff (rst)
        sum_valid_i |-> (state_q == fir_pkg::ISSUE || state_q == fir_pkg::DRAIN)
    ) else $error("block sum arrived outside the accumulate window");

endmodule

// File: fir_filter.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_filter (
    input  logic             clk,
    input  logic             rst,
    input  logic             pause_i,
    input  fir_pkg::sample_t sample_i,
    output logic             next_o,
    output logic             ready_o,
    output fir_pkg::acc_t    out_o
);

    logic                           shift;
    logic                           issue;
    logic [$clog2(`FIR_BLOCKS)-1:0] block_idx;
    logic                           sum_valid;
    fir_pkg::acc_t                  block_sum;

    // one block of lanes, history and ROM side
    fir_pkg::sample_t               taps [`FIR_LANES];
    fir_pkg::coef_t                 coefs [`FIR_LANES];

    fir_control u_control (
        .clk         (clk),
        .rst         (rst),
        .pause_i     (pause_i),
        .sum_valid_i (sum_valid),
        .block_sum_i (block_sum),
        .shift_o     (shift),
        .block_idx_o (block_idx),
        .issue_o     (issue),
        .next_o      (next_o),
        .ready_o     (ready_o),
        .out_o       (out_o)
    );

    sample_history u_history (
        .clk         (clk),
        .rst         (rst),
        .shift_i     (shift),
        .sample_i    (sample_i),
        .block_idx_i (block_idx),
        .taps_o      (taps)
    );

    // same block index as the history, so lanes pair up
    fir_coef_rom u_rom (
        .block_idx_i (block_idx),
        .coef_o      (coefs)
    );

    block_mac u_mac (
        .clk         (clk),
        .rst         (rst),
        .issue_i     (issue),
        .taps_i      (taps),
        .coef_i      (coefs),
        .sum_valid_o (sum_valid),
        .block_sum_o (block_sum)
    );

endmodule

// File: tb_fir_filter.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module tb_fir_filter;

    localparam int WAIT_LIMIT  = 50;
    localparam int READY_DELAY = `FIR_BLOCKS + 4;
    localparam int RANDOM_ROWS = 40;

    // impulse response h[0..15]
    localparam longint COEFS [`FIR_TAPS] = '{
        3, -7, 12, -20, 41, -85, 300, 1200,
        1200, 300, -85, 41, -20, 12, -7, 3
    };

    typedef struct {
        fir_pkg::sample_t smp;
        int               gap;
        longint           y_exp;
    } row_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             pause_i;
    fir_pkg::sample_t sample_i;
    logic             next_o;
    logic             ready_o;
    fir_pkg::acc_t    out_o;

    row_t   rows [$];
    longint ref_hist [`FIR_TAPS];
    longint last_y;

    fir_filter u_dut (
        .clk      (clk),
        .rst      (rst),
        .pause_i  (pause_i),
        .sample_i (sample_i),
        .next_o   (next_o),
        .ready_o  (ready_o),
        .out_o    (out_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        abort_run();
    endtask

    // newest sample at index 0, older ones behind it
    function automatic longint ref_filter_step(input fir_pkg::sample_t smp);
        longint y;
        for (int k = `FIR_TAPS - 1; k > 0; k--) begin
            ref_hist[k] = ref_hist[k-1];
        end
        ref_hist[0] = longint'(smp);
        y = 0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            y += COEFS[k] * ref_hist[k];
        end
        return y;
    endfunction

    task automatic push_row(input int smp, input int gap);
        row_t r;
        r.smp   = fir_pkg::sample_t'(smp);
        r.gap   = gap;
        r.y_exp = 0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int smp;
        int gap;
        // zero input straight after reset
        push_row(0, 1);
        // unit impulse, then zeros until it has left the history
        push_row(1, 0);
        for (int i = 0; i < `FIR_TAPS; i++) begin
            push_row(0, (i % 5 == 2) ? 3 : 0);
        end
        // full scale runs
        for (int i = 0; i < `FIR_TAPS; i++) begin
            push_row(32767, 0);
        end
        for (int i = 0; i < `FIR_TAPS; i++) begin
            push_row(-32768, (i == 7) ? 2 : 0);
        end
        for (int i = 0; i < 8; i++) begin
            push_row((i % 2 == 0) ? 32767 : -32768, 0);
        end
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            smp = int'($urandom_range(0, 65535)) - 32768;
            gap = int'($urandom_range(0, 3));
            push_row(smp, gap);
        end
        // expected outputs by direct convolution
        foreach (ref_hist[k]) begin
            ref_hist[k] = 0;
        end
        foreach (rows[i]) begin
            rows[i].y_exp = ref_filter_step(rows[i].smp);
        end
    endtask

    task automatic wait_next();
        int n;
        n = 0;
        @(negedge clk);
        while (!next_o) begin
            check_value("ready_o outside its slot", longint'(ready_o), 0);
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("next_o never went high");
            end
            @(negedge clk);
        end
        check_value("ready_o together with next_o", longint'(ready_o), 0);
    endtask

    // counts cycles from the request to the result
    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            check_value("next_o while a result is pending", longint'(next_o), 0);
            if (!ready_o) begin
                check_value("out_o before ready_o", longint'(out_o), last_y);
            end
            if (cycles > WAIT_LIMIT) begin
                report_timeout("ready_o never went high");
            end
        end while (!ready_o);
    endtask

    task automatic apply_row(input row_t row);
        int cycles;
        if (row.gap > 0) begin
            @(posedge clk);
            pause_i <= 1'b1;
            repeat (row.gap) begin
                @(negedge clk);
                check_value("next_o while paused", longint'(next_o), 0);
                check_value("ready_o while paused", longint'(ready_o), 0);
                check_value("out_o while paused", longint'(out_o), last_y);
            end
        end
        if (pause_i) begin
            @(posedge clk);
            pause_i <= 1'b0;
        end
        wait_next();
        // sample belongs to the cycle after the request
        @(posedge clk);
        sample_i <= row.smp;
        wait_ready(cycles);
        check_value("cycles from next_o to ready_o", cycles, READY_DELAY);
        check_value("out_o", longint'(out_o), row.y_exp);
        last_y = row.y_exp;
    endtask

    initial begin
        rst      = 1'b1;
        pause_i  = 1'b1;
        sample_i = '0;
        last_y   = 0;
        void'($urandom(32'haf3c_1672));
        build_table();

        // pause held through reset so nothing gets requested yet
        @(posedge clk);
        @(negedge clk);
        check_value("next_o in reset", longint'(next_o), 0);
        check_value("ready_o in reset", longint'(ready_o), 0);
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("next_o after reset", longint'(next_o), 0);
            check_value("ready_o after reset", longint'(ready_o), 0);
            check_value("out_o after reset", longint'(out_o), 0);
        end

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: fir_filter.f
+incdir+.
fir_pkg.sv
fir_coef_rom.sv
sample_history.sv
block_mac.sv
fir_control.sv
fir_filter.sv
tb_fir_filter.sv

// File: Makefile
# Verilator build and run for the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= tb_fir_filter
FILELIST  ?= fir_filter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
